//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // branch conditions
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    // funct3 of OP and OP-IMM, F3_SR covers srl and sra
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

endpackage

//--- logic/core_pipe_pkg.sv
package core_pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // operand source in EX
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    //////////////////////////////
    // stage registers
    //////////////////////////////

    typedef struct packed {
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        alu_op_e    alu_op;
        branch_f3_e funct3;
        logic       use_imm;
        logic       use_pc;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
    } id_ex_t;

    // result holds the alu output, the ram address or the link address
    typedef struct packed {
        word_t    result;
        word_t    store_data;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    data;
        reg_idx_t rd;
        logic     reg_write;
    } mem_wb_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import rv_isa_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  redirect_i,
    input  word_t redirect_pc_i,
    output word_t rom_addr_o,
    input  word_t rom_data_i,
    output word_t if_instr_o,
    output word_t if_pc_o
);

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    word_t pc_q;
    word_t instr_q;
    word_t if_pc_q;

    // redirect wins over stall
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_q <= NOP_INSTR;
            if_pc_q <= '0;
        end else if (redirect_i) begin
            instr_q <= NOP_INSTR;
            if_pc_q <= '0;
        end else if (!stall_i) begin
            instr_q <= rom_data_i;
            if_pc_q <= pc_q;
        end
    end

    assign rom_addr_o = pc_q;
    assign if_instr_o = instr_q;
    assign if_pc_o    = if_pc_q;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o,
    input  mem_wb_t  wb_i
);

    // x0 has no storage
    word_t regs_q [1:31];
    logic  wr_en;

    assign wr_en = wb_i.reg_write && (wb_i.rd != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // same-cycle write is passed straight through
    assign rs1_data_o = (rs1_i == '0)                 ? '0 :
                        (wr_en && wb_i.rd == rs1_i)   ? wb_i.data : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0)                 ? '0 :
                        (wr_en && wb_i.rd == rs2_i)   ? wb_i.data : regs_q[rs2_i];

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  word_t   if_instr_i,
    input  word_t   if_pc_i,
    input  logic    redirect_i,
    input  mem_wb_t wb_i,
    output logic    stall_o,
    output id_ex_t  id_ex_o
);

    opcode_e    opcode;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [2:0] funct3;
    logic       funct7_alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       stall;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;

    // sub only exists in the register form, sra/srai in both
    function automatic alu_op_e alu_decode(alu_f3_e f3, logic alt, logic is_reg);
        case (f3)
            F3_ADD:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode     = opcode_e'(if_instr_i[6:0]);
    assign rd         = if_instr_i[11:7];
    assign funct3     = if_instr_i[14:12];
    assign rs1        = if_instr_i[19:15];
    assign rs2        = if_instr_i[24:20];
    assign funct7_alt = if_instr_i[30];

    // immediate formats
    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
    assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};
    assign imm_u = {if_instr_i[31:12], 12'b0};
    assign imm_j = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                    if_instr_i[20], if_instr_i[30:21], 1'b0};

    reg_file reg_file_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    //////////////////////////////
    // main decoder
    //////////////////////////////

    always_comb begin
        id_ex_d        = '0;
        uses_rs1       = 1'b0;
        uses_rs2       = 1'b0;
        id_ex_d.pc     = if_pc_i;
        id_ex_d.rd     = rd;
        id_ex_d.funct3 = branch_f3_e'(funct3);
        case (opcode)
            OP_LUI: begin
                id_ex_d.imm       = imm_u;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.alu_op    = ALU_PASS_B;
                id_ex_d.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                id_ex_d.imm       = imm_u;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.use_pc    = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            OP_JAL: begin
                id_ex_d.imm       = imm_j;
                id_ex_d.is_jal    = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            OP_JALR: begin
                uses_rs1          = 1'b1;
                id_ex_d.imm       = imm_i;
                id_ex_d.is_jalr   = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            OP_BRANCH: begin
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = 1'b1;
            end
            OP_LOAD: begin
                uses_rs1          = 1'b1;
                id_ex_d.imm       = imm_i;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.mem_read  = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            OP_STORE: begin
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
                id_ex_d.imm       = imm_s;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.mem_write = 1'b1;
            end
            OP_IMM: begin
                uses_rs1          = 1'b1;
                id_ex_d.imm       = imm_i;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.alu_op    = alu_decode(alu_f3_e'(funct3), funct7_alt, 1'b0);
                id_ex_d.reg_write = 1'b1;
            end
            OP_REG: begin
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
                id_ex_d.alu_op    = alu_decode(alu_f3_e'(funct3), funct7_alt, 1'b1);
                id_ex_d.reg_write = 1'b1;
            end
            default: begin
                // unknown opcode runs as a bubble
                id_ex_d.rd = '0;
            end
        endcase
        // unread fields must not match in forwarding
        id_ex_d.rs1      = uses_rs1 ? rs1 : '0;
        id_ex_d.rs2      = uses_rs2 ? rs2 : '0;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
    end

    // load in EX feeding the instruction in ID
    assign stall = id_ex_q.mem_read && (id_ex_q.rd != '0) &&
                   ((uses_rs1 && id_ex_q.rd == rs1) || (uses_rs2 && id_ex_q.rd == rs2));

    // ID/EX register, bubble on stall or flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (redirect_i || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign stall_o = stall;
    assign id_ex_o = id_ex_q;

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  id_ex_t  id_ex_i,
    input  mem_wb_t wb_i,
    output logic    redirect_o,
    output word_t   redirect_pc_o,
    output ex_mem_t ex_mem_o
);

    fwd_sel_e rs1_sel;
    fwd_sel_e rs2_sel;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_out;
    word_t    jalr_sum;
    logic     taken;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;

    // younger producer first
    function automatic fwd_sel_e fwd_select(reg_idx_t rs, ex_mem_t mem, mem_wb_t wb);
        if (mem.reg_write && mem.rd != '0 && mem.rd == rs) begin
            return FWD_MEM;
        end else if (wb.reg_write && wb.rd != '0 && wb.rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_sel = fwd_select(id_ex_i.rs1, ex_mem_q, wb_i);
    assign rs2_sel = fwd_select(id_ex_i.rs2, ex_mem_q, wb_i);
    assign rs1_val = fwd_mux(rs1_sel, id_ex_i.rs1_data, ex_mem_q.result, wb_i.data);
    assign rs2_val = fwd_mux(rs2_sel, id_ex_i.rs2_data, ex_mem_q.result, wb_i.data);

    //////////////////////////////
    // alu
    //////////////////////////////

    assign op_a = id_ex_i.use_pc  ? id_ex_i.pc  : rs1_val;
    assign op_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    //////////////////////////////
    // branch and jump
    //////////////////////////////

    always_comb begin
        case (id_ex_i.funct3)
            BEQ:     taken = (rs1_val == rs2_val);
            BNE:     taken = (rs1_val != rs2_val);
            BLT:     taken = ($signed(rs1_val) < $signed(rs2_val));
            BGE:     taken = ($signed(rs1_val) >= $signed(rs2_val));
            BLTU:    taken = (rs1_val < rs2_val);
            BGEU:    taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = id_ex_i.is_jal || id_ex_i.is_jalr || (id_ex_i.is_branch && taken);

    // jalr target has bit 0 forced low
    assign jalr_sum      = rs1_val + id_ex_i.imm;
    assign redirect_pc_o = id_ex_i.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0}
                                           : id_ex_i.pc + id_ex_i.imm;

    always_comb begin
        ex_mem_d            = '0;
        ex_mem_d.result     = (id_ex_i.is_jal || id_ex_i.is_jalr) ? id_ex_i.pc + 32'd4
                                                                  : alu_out;
        ex_mem_d.store_data = rs2_val;
        ex_mem_d.rd         = id_ex_i.rd;
        ex_mem_d.mem_read   = id_ex_i.mem_read;
        ex_mem_d.mem_write  = id_ex_i.mem_write;
        ex_mem_d.reg_write  = id_ex_i.reg_write;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_mem_d;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

//--- logic/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  ex_mem_t ex_mem_i,
    output word_t   ram_addr_o,
    output word_t   ram_wdata_o,
    output logic    ram_we_o,
    input  word_t   ram_rdata_i,
    output mem_wb_t mem_wb_o
);

    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    // ram answers in the same cycle
    assign ram_addr_o  = ex_mem_i.result;
    assign ram_wdata_o = ex_mem_i.store_data;
    assign ram_we_o    = ex_mem_i.mem_write;

    // writeback select
    always_comb begin
        mem_wb_d.data      = ex_mem_i.mem_read ? ram_rdata_i : ex_mem_i.result;
        mem_wb_d.rd        = ex_mem_i.rd;
        mem_wb_d.reg_write = ex_mem_i.reg_write;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= mem_wb_d;
        end
    end

    assign mem_wb_o = mem_wb_q;

endmodule

//--- logic/riscv_core.sv
`timescale 1ns/1ps

module riscv_core
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n_i,
    output word_t rom_addr_o,
    input  word_t rom_data_i,
    output word_t ram_addr_o,
    output word_t ram_wdata_o,
    output logic  ram_we_o,
    input  word_t ram_rdata_i
);

    // IF/ID
    word_t   if_instr;
    word_t   if_pc;
    // control back to fetch
    logic    stall;
    logic    redirect;
    word_t   redirect_pc;
    // stage registers
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .rom_addr_o    (rom_addr_o),
        .rom_data_i    (rom_data_i),
        .if_instr_o    (if_instr),
        .if_pc_o       (if_pc)
    );

    decode_stage decode_stage_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .if_instr_i (if_instr),
        .if_pc_i    (if_pc),
        .redirect_i (redirect),
        .wb_i       (mem_wb),
        .stall_o    (stall),
        .id_ex_o    (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_ex_i       (id_ex),
        .wb_i          (mem_wb),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_mem_o      (ex_mem)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_mem_i    (ex_mem),
        .ram_addr_o  (ram_addr_o),
        .ram_wdata_o (ram_wdata_o),
        .ram_we_o    (ram_we_o),
        .ram_rdata_i (ram_rdata_i),
        .mem_wb_o    (mem_wb)
    );

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

//--- sim/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    typedef logic [31:0] word_t;

    localparam word_t RESET_PC   = 32'h0000_0040;
    localparam word_t NOP        = 32'h0000_0013;
    localparam word_t LFSR_SEED  = 32'hc4bc_1460;
    localparam int    WAIT_LIMIT = 200;

    // one program of up to 16 words and the store it must end with
    typedef struct packed {
        logic [15:0][31:0] prog;
        word_t             exp_addr;
        word_t             exp_data;
        logic              use_ram;
        logic [7:0]        ram_word;
    } test_case_t;

    logic  clk;
    logic  rst_n;
    word_t rom_addr;
    word_t rom_data;
    word_t ram_addr;
    word_t ram_wdata;
    logic  ram_we;
    word_t ram_rdata;

    word_t rom [0:255];
    word_t ram [0:255];
    word_t ram_init [0:255];

    test_case_t cases[$];
    string      names[$];
    word_t      prog_q[$];

    clk_gen #(
        .PERIOD_NS (4)
    ) clk_gen_inst (
        .clk_o (clk)
    );

    riscv_core #(
        .RESET_PC (RESET_PC)
    ) riscv_core_inst (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .rom_addr_o  (rom_addr),
        .rom_data_i  (rom_data),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_we_o    (ram_we),
        .ram_rdata_i (ram_rdata)
    );

    //////////////////////////////
    // memory models
    //////////////////////////////

    assign rom_data  = rom[rom_addr[9:2]];
    assign ram_rdata = ram[ram_addr[9:2]];

    // ram image is restored while reset is held
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= ram_init[i];
            end
        end else if (ram_we) begin
            ram[ram_addr[9:2]] <= ram_wdata;
        end
    end

    //////////////////////////////
    // instruction encoding
    //////////////////////////////

    function automatic word_t op_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                     logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t op_reg(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t load_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t store_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jump_link(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t jump_reg(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic word_t upper(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // beq x0, x0, 0
    function automatic word_t self_loop();
        return branch(3'd0, 5'd0, 5'd0, 13'd0);
    endfunction

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic word_t lfsr_step(word_t state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic build_ram_image();
        word_t lfsr;
        word_t value;
        lfsr = LFSR_SEED;
        for (int w = 0; w < 256; w++) begin
            value = '0;
            for (int b = 0; b < 32; b++) begin
                value = {value[30:0], lfsr[0]};
                lfsr  = lfsr_step(lfsr);
            end
            ram_init[w] = value;
        end
    endtask

    task automatic add_case(string name, word_t addr, word_t data, logic use_ram,
                            logic [7:0] ram_word);
        test_case_t tc;
        tc.prog = {16{NOP}};
        for (int i = 0; i < prog_q.size() && i < 16; i++) begin
            tc.prog[i] = prog_q[i];
        end
        tc.exp_addr = addr;
        tc.exp_data = data;
        tc.use_ram  = use_ram;
        tc.ram_word = ram_word;
        cases.push_back(tc);
        names.push_back(name);
        prog_q.delete();
    endtask

    //////////////////////////////
    // program table
    //////////////////////////////

    task automatic build_table();
        // x1 = 100, x2 = -7
        prog_q.push_back(op_imm(3'd0, 5'd1, 5'd0, 12'd100));
        prog_q.push_back(op_imm(3'd0, 5'd2, 5'd0, 12'hff9));
        // add 0x5d, sub 0x6b, xor 0x36, or 0x76, and 0x62
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
        prog_q.push_back(op_reg(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
        prog_q.push_back(op_reg(7'h00, 3'd4, 5'd5, 5'd3, 5'd4));
        prog_q.push_back(op_reg(7'h00, 3'd6, 5'd6, 5'd5, 5'd1));
        prog_q.push_back(op_reg(7'h00, 3'd7, 5'd7, 5'd6, 5'd4));
        // slt and sltu both give 1
        prog_q.push_back(op_reg(7'h00, 3'd2, 5'd8, 5'd2, 5'd1));
        prog_q.push_back(op_reg(7'h00, 3'd3, 5'd9, 5'd1, 5'd2));
        // sll to 0xc4, srai to -4, srli 28 to 0xf
        prog_q.push_back(op_reg(7'h00, 3'd1, 5'd10, 5'd7, 5'd9));
        prog_q.push_back(op_imm(3'd5, 5'd11, 5'd2, 12'h401));
        prog_q.push_back(op_imm(3'd5, 5'd12, 5'd11, 12'd28));
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd13, 5'd10, 5'd12));
        prog_q.push_back(op_reg(7'h20, 3'd0, 5'd14, 5'd13, 5'd8));
        prog_q.push_back(store_word(5'd14, 5'd0, 12'h100));
        prog_q.push_back(self_loop());
        add_case("alu", 32'h0000_0100, 32'h0000_00d2, 1'b0, 8'd0);

        // x1 = 5 read one, two and three instructions later
        prog_q.push_back(op_imm(3'd0, 5'd1, 5'd0, 12'd5));
        prog_q.push_back(op_imm(3'd0, 5'd2, 5'd1, 12'd3));
        prog_q.push_back(op_imm(3'd0, 5'd3, 5'd1, 12'd10));
        prog_q.push_back(op_imm(3'd0, 5'd4, 5'd1, 12'd20));
        // 8 + 15, then + 25, then - 8
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd5, 5'd2, 5'd3));
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd6, 5'd5, 5'd4));
        prog_q.push_back(op_reg(7'h20, 3'd0, 5'd7, 5'd6, 5'd2));
        prog_q.push_back(store_word(5'd7, 5'd0, 12'h104));
        prog_q.push_back(self_loop());
        add_case("dependencies", 32'h0000_0104, 32'h0000_0028, 1'b0, 8'd0);

        // lw from 0xc0 (word 48), add right behind it
        prog_q.push_back(op_imm(3'd0, 5'd4, 5'd0, 12'h123));
        prog_q.push_back(op_imm(3'd0, 5'd1, 5'd0, 12'h080));
        prog_q.push_back(load_word(5'd2, 5'd1, 12'h040));
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd3, 5'd4, 5'd2));
        prog_q.push_back(store_word(5'd3, 5'd0, 12'h108));
        prog_q.push_back(self_loop());
        add_case("load_use", 32'h0000_0108, 32'h0000_0123, 1'b1, 8'd48);

        // x1 = 1, x2 = -1, x10 collects the instructions that ran
        prog_q.push_back(op_imm(3'd0, 5'd1, 5'd0, 12'd1));
        prog_q.push_back(op_imm(3'd0, 5'd2, 5'd0, 12'hfff));
        prog_q.push_back(branch(3'd0, 5'd1, 5'd2, 13'd8));
        prog_q.push_back(op_imm(3'd0, 5'd10, 5'd10, 12'h001));
        prog_q.push_back(branch(3'd1, 5'd1, 5'd2, 13'd12));
        prog_q.push_back(op_imm(3'd0, 5'd10, 5'd10, 12'h010));
        prog_q.push_back(op_imm(3'd0, 5'd10, 5'd10, 12'h020));
        prog_q.push_back(branch(3'd4, 5'd2, 5'd1, 13'd12));
        prog_q.push_back(op_imm(3'd0, 5'd10, 5'd10, 12'h040));
        prog_q.push_back(op_imm(3'd0, 5'd10, 5'd10, 12'h080));
        // bgeu 1 >= 0xffffffff is false
        prog_q.push_back(branch(3'd7, 5'd1, 5'd2, 13'd8));
        prog_q.push_back(op_imm(3'd0, 5'd10, 5'd10, 12'h100));
        prog_q.push_back(store_word(5'd10, 5'd0, 12'h10c));
        prog_q.push_back(self_loop());
        add_case("branches", 32'h0000_010c, 32'h0000_0101, 1'b0, 8'd0);

        // lui, auipc at pc 0x44, jal at pc 0x48 over two slots
        prog_q.push_back(upper(7'b0110111, 5'd1, 20'h12345));
        prog_q.push_back(upper(7'b0010111, 5'd2, 20'h00001));
        prog_q.push_back(jump_link(5'd3, 21'd12));
        prog_q.push_back(op_imm(3'd0, 5'd1, 5'd0, 12'd0));
        prog_q.push_back(op_imm(3'd0, 5'd2, 5'd0, 12'd0));
        // jalr at pc 0x58 to 0x61 + 4 with bit 0 cleared
        prog_q.push_back(op_imm(3'd0, 5'd4, 5'd0, 12'h061));
        prog_q.push_back(jump_reg(5'd5, 5'd4, 12'd4));
        prog_q.push_back(op_imm(3'd0, 5'd1, 5'd0, 12'd0));
        prog_q.push_back(op_imm(3'd0, 5'd2, 5'd0, 12'd0));
        // auipc at the jalr target sees the pc 0x64
        prog_q.push_back(upper(7'b0010111, 5'd7, 20'h00000));
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd6, 5'd1, 5'd2));
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd6, 5'd6, 5'd3));
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd6, 5'd6, 5'd5));
        prog_q.push_back(op_reg(7'h00, 3'd0, 5'd6, 5'd6, 5'd7));
        prog_q.push_back(store_word(5'd6, 5'd0, 12'h110));
        prog_q.push_back(self_loop());
        add_case("jumps_upper", 32'h0000_0110, 32'h1234_6150, 1'b0, 8'd0);
    endtask

    //////////////////////////////
    // checks and case runner
    //////////////////////////////

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_rom(int idx);
        for (int i = 0; i < 256; i++) begin
            rom[i] = NOP;
        end
        for (int j = 0; j < 16; j++) begin
            rom[int'(RESET_PC[9:2]) + j] = cases[idx].prog[j];
        end
    endtask

    task automatic run_case(int idx);
        int    cycles;
        logic  seen;
        word_t exp_data;
        @(negedge clk);
        rst_n = 1'b0;
        load_rom(idx);
        repeat (5) begin
            @(negedge clk);
            check_value({names[idx], " reset rom_addr"}, RESET_PC, rom_addr);
            check_value({names[idx], " reset ram_we"}, 32'd0, {31'd0, ram_we});
        end
        rst_n = 1'b1;
        // first cycle out of reset still fetches from the reset pc
        check_value({names[idx], " first rom_addr"}, RESET_PC, rom_addr);
        check_value({names[idx], " first ram_we"}, 32'd0, {31'd0, ram_we});

        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            seen = ram_we;
        end
        if (!seen) begin
            $display("timeout: test %s made no RAM write in %0d cycles", names[idx],
                     WAIT_LIMIT);
            $display("Verification failed");
            $fatal(1, "no store seen");
        end

        exp_data = cases[idx].exp_data;
        if (cases[idx].use_ram) begin
            exp_data = exp_data + ram_init[cases[idx].ram_word];
        end
        check_value({names[idx], " addr"}, cases[idx].exp_addr, ram_addr);
        check_value({names[idx], " data"}, exp_data, ram_wdata);
    endtask

    initial begin
        rst_n = 1'b0;
        build_ram_image();
        for (int i = 0; i < 256; i++) begin
            rom[i] = NOP;
        end
        build_table();
        for (int i = 0; i < cases.size(); i++) begin
            run_case(i);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

//--- build.f
logic/rv_isa_pkg.sv
logic/core_pipe_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/riscv_core.sv
sim/clk_gen.sv
sim/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the core and its testbench with Verilator, then run it

if ! cd "$(dirname "$0")"; then
    echo "cannot enter the project directory"
    exit 1
fi

if ! verilator --binary --timing --top-module core_tb -f build.f -o core_tb_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/core_tb_sim)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
